/* common/rob_pkg.sv */
`default_nettype none

package rob_pkg;

   localparam int ROB_DEPTH     = 8;
   localparam int ROB_IDX_W     = 3;
   localparam int NUM_ARCH_REGS = 16;
   localparam int DATA_W        = 16;
   localparam int LAT_W         = 4;

   typedef logic [$clog2(NUM_ARCH_REGS)-1:0] t_reg_addr;
   typedef logic [DATA_W-1:0]                t_data;
   typedef logic [LAT_W-1:0]                 t_latency;   // 0 behaves as 1
   typedef logic [ROB_IDX_W-1:0]             t_rob_idx;

   typedef struct packed {
      logic     wrap;   // Tells full from empty
      t_rob_idx idx;
   } t_rob_id;

   typedef struct packed {
      t_reg_addr dst;
      t_reg_addr src;
      t_data     imm;
      t_latency  latency;
      logic      exc;
   } t_instr;

   typedef struct packed {
      t_rob_id  robid;
      t_data    value;
      t_latency latency;
   } t_exec_req;

   typedef struct packed {
      t_rob_id robid;
      t_data   value;
   } t_exec_result;

   typedef struct packed {
      t_reg_addr dst;
      t_data     value;
      logic      exc;
   } t_retire_pkt;

   typedef struct packed {
      t_reg_addr dst;
      logic      exc;
      logic      done;
      t_data     value;
   } t_rob_ent;

   // Wrap bit flips once per lap of the buffer
   function automatic t_rob_id incr_robid(input t_rob_id id);
      return t_rob_id'(id + (ROB_IDX_W+1)'(1));
   endfunction

endpackage

`default_nettype wire

/* rob/rob_entry.sv */
`timescale 1ns/100ps
`default_nettype none

module rob_entry import rob_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      alloc_en,
   input  t_reg_addr alloc_dst,
   input  logic      alloc_exc,
   input  logic      cmpl_en,
   input  t_data     cmpl_value,
   input  logic      retire_en,
   input  logic      flush,
   output logic      ent_valid,
   output t_rob_ent  ent
);

   logic      done;
   logic      exc;
   t_reg_addr dst;
   t_data     value;
   logic      cmpl_hit;

   assign cmpl_hit = cmpl_en & ent_valid;   // Ignore strays on a free entry

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ent_valid <= 1'b0;
         done      <= 1'b0;
      end else if (flush || retire_en) begin
         ent_valid <= 1'b0;
         done      <= 1'b0;
      end else if (alloc_en) begin
         ent_valid <= 1'b1;
         done      <= 1'b0;
      end else if (cmpl_hit) begin
         done <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_en) begin
         dst <= alloc_dst;
         exc <= alloc_exc;
      end
      if (cmpl_hit) begin
         value <= cmpl_value;
      end
   end

   always_comb begin
      ent.dst   = dst;
      ent.exc   = exc;
      ent.done  = done;
      ent.value = value;
   end

endmodule

`default_nettype wire

/* rob/rob.sv */
`timescale 1ns/100ps
`default_nettype none

module rob import rob_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,

   input  logic         alloc,
   input  t_reg_addr    alloc_dst,
   input  logic         alloc_exc,
   output t_rob_id      next_robid,
   output logic         rob_full,

   input  logic         cmpl_valid,
   input  t_exec_result cmpl,

   input  t_reg_addr    src_addr,
   output logic         src_pending,

   output logic         head_valid,
   output t_rob_ent     head_ent,
   input  logic         retire,

   input  logic         flush
);

   t_rob_id              head;   // Oldest entry
   t_rob_id              tail;   // Next to allocate
   logic                 rob_empty;

   logic [ROB_DEPTH-1:0] e_alloc;
   logic [ROB_DEPTH-1:0] e_cmpl;
   logic [ROB_DEPTH-1:0] e_retire;
   logic [ROB_DEPTH-1:0] ent_valid;
   logic [ROB_DEPTH-1:0] src_match;
   t_rob_ent             entries [ROB_DEPTH];

   assign rob_empty  = (head == tail);
   assign rob_full   = (head.idx == tail.idx) && (head.wrap != tail.wrap);
   assign next_robid = tail;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (alloc) begin
            tail <= incr_robid(tail);
         end
         if (flush) begin
            head <= tail;   // Drops every younger entry
         end else if (retire) begin
            head <= incr_robid(head);
         end
      end
   end

   // One-hot entry enables
   assign e_alloc  = alloc ? (ROB_DEPTH'(1) << tail.idx) : '0;
   assign e_cmpl   = cmpl_valid ? (ROB_DEPTH'(1) << cmpl.robid.idx) : '0;
   assign e_retire = retire ? (ROB_DEPTH'(1) << head.idx) : '0;

   for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entries
      rob_entry u_entry (
         .clk        (clk),
         .rst_n      (rst_n),
         .alloc_en   (e_alloc[i]),
         .alloc_dst  (alloc_dst),
         .alloc_exc  (alloc_exc),
         .cmpl_en    (e_cmpl[i]),
         .cmpl_value (cmpl.value),
         .retire_en  (e_retire[i]),
         .flush      (flush),
         .ent_valid  (ent_valid[i]),
         .ent        (entries[i])
      );

      assign src_match[i] = ent_valid[i] & (entries[i].dst == src_addr);
   end

   assign src_pending = |src_match;

   assign head_ent   = entries[head.idx];
   assign head_valid = ~rob_empty & head_ent.done;

endmodule

`default_nettype wire

/* dispatch/dispatch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage import rob_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,

   input  logic      in_valid,
   input  t_instr    in_instr,
   output logic      in_ready,

   output t_reg_addr src_addr,
   input  logic      src_pending,
   output t_reg_addr rd_addr,
   input  t_data     rd_data,

   input  t_rob_id   next_robid,
   input  logic      rob_full,
   output logic      alloc,
   output t_reg_addr alloc_dst,
   output logic      alloc_exc,

   input  logic      exec_free,
   output logic      exec_valid,
   output t_exec_req exec_req,

   input  logic      flush
);

   logic accept;

   assign src_addr = in_instr.src;
   assign rd_addr  = in_instr.src;

   assign in_ready = ~rob_full & ~src_pending & exec_free & ~flush;
   assign accept   = in_valid & in_ready;

   assign alloc     = accept;
   assign alloc_dst = in_instr.dst;
   assign alloc_exc = in_instr.exc;

   assign exec_valid = accept;

   always_comb begin
      exec_req.robid   = next_robid;
      exec_req.value   = rd_data + in_instr.imm;   // Wraps at 2^16
      exec_req.latency = in_instr.latency;
   end

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rob_pkg::*; #(
   parameter int EXEC_SLOTS = 4
) (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         exec_valid,
   input  t_exec_req    exec_req,
   input  logic         flush,
   output logic         exec_free,
   output logic         cmpl_valid,
   output t_exec_result cmpl
);

   typedef struct packed {
      t_rob_id  robid;
      t_data    value;
      t_latency cnt;   // Cycles left
   } t_slot;

   t_slot                 slots [EXEC_SLOTS];
   logic [EXEC_SLOTS-1:0] busy;
   logic [EXEC_SLOTS-1:0] ready;
   logic [EXEC_SLOTS-1:0] load_oh;
   logic [EXEC_SLOTS-1:0] cmpl_oh;

   // Walk down so the lowest index wins both searches
   always_comb begin
      load_oh = '0;
      cmpl_oh = '0;
      cmpl    = '0;
      for (int i = EXEC_SLOTS-1; i >= 0; i--) begin
         ready[i] = busy[i] & (slots[i].cnt == '0);
         if (!busy[i]) begin
            load_oh = EXEC_SLOTS'(1) << i;
         end
         if (ready[i]) begin
            cmpl_oh     = EXEC_SLOTS'(1) << i;
            cmpl.robid  = slots[i].robid;
            cmpl.value  = slots[i].value;
         end
      end
   end

   assign exec_free  = ~&busy;
   assign cmpl_valid = |ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else if (flush) begin
         busy <= '0;   // Kill everything in flight
      end else begin
         busy <= (busy & ~cmpl_oh) | (exec_valid ? load_oh : '0);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < EXEC_SLOTS; i++) begin
         if (exec_valid && load_oh[i]) begin
            slots[i].robid <= exec_req.robid;
            slots[i].value <= exec_req.value;
            slots[i].cnt   <= (exec_req.latency == '0) ? LAT_W'(1) : exec_req.latency;
         end else if (slots[i].cnt != '0) begin
            slots[i].cnt <= slots[i].cnt - LAT_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/retire_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module retire_stage import rob_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,

   input  logic        head_valid,
   input  t_rob_ent    head_ent,
   output logic        retire,
   output logic        flush,

   output logic        ret_valid,
   output t_retire_pkt ret_pkt,
   input  logic        ret_ready,

   input  t_reg_addr   rd_addr,
   output t_data       rd_data
);

   t_data arch_rf [NUM_ARCH_REGS];

   assign ret_valid = head_valid;

   always_comb begin
      ret_pkt.dst   = head_ent.dst;
      ret_pkt.value = head_ent.value;
      ret_pkt.exc   = head_ent.exc;
   end

   assign retire = ret_valid & ret_ready;
   assign flush  = retire & head_ent.exc;   // Exception packet taken

   assign rd_data = arch_rf[rd_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            arch_rf[i] <= '0;
         end
      end else if (retire && !head_ent.exc) begin
         arch_rf[head_ent.dst] <= head_ent.value;
      end
   end

endmodule

`default_nettype wire

/* verilog/rob_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rob_core import rob_pkg::*; #(
   parameter int EXEC_SLOTS = 4
) (
   input  logic        clk,
   input  logic        rst_n,

   input  logic        in_valid,
   input  t_instr      in_instr,
   output logic        in_ready,

   output logic        ret_valid,
   output t_retire_pkt ret_pkt,
   input  logic        ret_ready
);

   t_reg_addr    src_addr;
   logic         src_pending;
   t_reg_addr    rd_addr;
   t_data        rd_data;
   t_rob_id      next_robid;
   logic         rob_full;
   logic         alloc;
   t_reg_addr    alloc_dst;
   logic         alloc_exc;
   logic         exec_valid;
   t_exec_req    exec_req;
   logic         exec_free;
   logic         cmpl_valid;
   t_exec_result cmpl;
   logic         head_valid;
   t_rob_ent     head_ent;
   logic         retire;
   logic         flush;

   dispatch_stage u_dispatch (
      .clk, .rst_n,
      .in_valid, .in_instr, .in_ready,
      .src_addr, .src_pending, .rd_addr, .rd_data,
      .next_robid, .rob_full, .alloc, .alloc_dst, .alloc_exc,
      .exec_free, .exec_valid, .exec_req,
      .flush
   );

   rob u_rob (
      .clk, .rst_n,
      .alloc, .alloc_dst, .alloc_exc, .next_robid, .rob_full,
      .cmpl_valid, .cmpl,
      .src_addr, .src_pending,
      .head_valid, .head_ent, .retire,
      .flush
   );

   exec_unit #(.EXEC_SLOTS(EXEC_SLOTS)) u_exec (
      .clk, .rst_n,
      .exec_valid, .exec_req, .flush,
      .exec_free, .cmpl_valid, .cmpl
   );

   retire_stage u_retire (
      .clk, .rst_n,
      .head_valid, .head_ent, .retire, .flush,
      .ret_valid, .ret_pkt, .ret_ready,
      .rd_addr, .rd_data
   );

endmodule

`default_nettype wire

/* testbench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH
`default_nettype none

// All tasks start and return on a falling edge

task automatic fail_run(input string why);
   $display("%s", why);
   $display("Simulation failed");
   $fatal(1, "Stopping at first error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
   if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
   end
endtask

function automatic t_instr make_instr(input t_reg_addr dst, input t_reg_addr src,
                                      input t_data imm, input t_latency lat, input logic exc);
   t_instr instr;
   instr.dst     = dst;
   instr.src     = src;
   instr.imm     = imm;
   instr.latency = lat;
   instr.exc     = exc;
   return instr;
endfunction

function automatic t_latency rand_latency();
   return t_latency'((($random(seed) & 32'h7fff_ffff) % 15) + 1);   // 1 to 15
endfunction

function automatic t_data rand_imm();
   return t_data'($random(seed));
endfunction

task automatic send_instr(input t_instr instr);
   int cycles;
   cycles   = 0;
   in_valid = 1'b1;
   in_instr = instr;
   #1;
   while (!in_ready) begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
         fail_run("Timeout: instruction was never accepted");
      end
   end
   @(posedge clk);
   sent_q.push_back(instr);
   @(negedge clk);
   in_valid = 1'b0;
endtask

// Expected value is src plus imm against the model state at retirement
task automatic expect_retire();
   int     cycles;
   t_instr instr;
   t_data  exp_value;
   cycles = 0;
   while (!ret_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
         fail_run("Timeout: no retire packet arrived");
      end
   end
   if (sent_q.size() == 0) begin
      fail_run("Retire packet arrived with no instruction outstanding");
   end
   instr     = sent_q.pop_front();
   exp_value = model_rf[instr.src] + instr.imm;
   check_value("ret_pkt.dst", 32'(ret_pkt.dst), 32'(instr.dst));
   check_value("ret_pkt.value", 32'(ret_pkt.value), 32'(exp_value));
   check_value("ret_pkt.exc", 32'(ret_pkt.exc), 32'(instr.exc));
   if (!instr.exc) begin
      model_rf[instr.dst] = exp_value;
   end
   @(posedge clk);
   @(negedge clk);
endtask

`default_nettype wire
`endif

/* testbench/tb_rob_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rob_core import rob_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int TIMEOUT    = 200;   // Cycles allowed per wait

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   t_instr      in_instr;
   logic        in_ready;
   logic        ret_valid;
   t_retire_pkt ret_pkt;
   logic        ret_ready;

   t_data  model_rf [NUM_ARCH_REGS];   // Register state as retired so far
   t_instr sent_q [$];                 // Accepted, not yet retired
   integer seed = 32'ha8d5;

   rob_core #(.EXEC_SLOTS(4)) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_instr  (in_instr),
      .in_ready  (in_ready),
      .ret_valid (ret_valid),
      .ret_pkt   (ret_pkt),
      .ret_ready (ret_ready)
   );

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic single_retire();
      check_value("in_ready", 32'(in_ready), 32'(1));
      check_value("ret_valid", 32'(ret_valid), 32'(0));
      send_instr(make_instr(4'd1, 4'd0, 16'h1234, 4'd3, 1'b0));
      expect_retire();
   endtask

   // Random latencies so completions come back out of order
   task automatic independent_burst();
      fork
         for (int i = 1; i <= 8; i++) begin
            send_instr(make_instr(t_reg_addr'(i), 4'd0, rand_imm(), rand_latency(), 1'b0));
         end
         repeat (8) expect_retire();
      join
   endtask

   task automatic dependent_chain();
      fork
         for (int i = 10; i <= 14; i++) begin
            send_instr(make_instr(t_reg_addr'(i), (i == 10) ? 4'd1 : t_reg_addr'(i-1),
                                  rand_imm(), rand_latency(), 1'b0));
         end
         repeat (5) expect_retire();
      join
   endtask

   task automatic backpressure_fill();
      ret_ready = 1'b0;
      for (int i = 1; i <= 8; i++) begin
         send_instr(make_instr(t_reg_addr'(i), 4'd0, rand_imm(), rand_latency(), 1'b0));
      end
      in_instr = make_instr(4'd9, 4'd0, 16'h0909, 4'd2, 1'b0);
      in_valid = 1'b1;   // Ninth one offered
      // Longer than any latency, so only the full ROB can hold in_ready low
      for (int i = 0; i < 20; i++) begin
         #1;
         check_value("in_ready", 32'(in_ready), 32'(0));
         @(negedge clk);
      end
      check_value("ret_valid", 32'(ret_valid), 32'(1));
      ret_ready = 1'b1;
      fork
         send_instr(in_instr);
         repeat (9) expect_retire();
      join
   endtask

   task automatic exception_flush();
      send_instr(make_instr(4'd12, 4'd0, 16'h0abc, 4'd2, 1'b0));
      expect_retire();
      send_instr(make_instr(4'd12, 4'd0, 16'h5555, 4'd15, 1'b1));   // Slow, stays at head
      send_instr(make_instr(4'd12, 4'd0, 16'h1111, 4'd1, 1'b0));
      send_instr(make_instr(4'd12, 4'd0, 16'h2222, 4'd1, 1'b0));
      expect_retire();
      sent_q.delete();   // Younger ones are gone
      for (int i = 0; i < 20; i++) begin
         check_value("ret_valid", 32'(ret_valid), 32'(0));
         @(negedge clk);
      end
      send_instr(make_instr(4'd13, 4'd12, 16'h0000, 4'd1, 1'b0));
      expect_retire();
   endtask

   task automatic flush_recovery();
      fork
         begin
            for (int i = 1; i <= 5; i++) begin
               send_instr(make_instr(t_reg_addr'(i), 4'd0, rand_imm(), rand_latency(), 1'b0));
            end
            send_instr(make_instr(4'd6, 4'd5, rand_imm(), rand_latency(), 1'b0));
         end
         repeat (6) expect_retire();
      join
   endtask

   initial begin
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_instr  = '0;
      ret_ready = 1'b1;
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
         model_rf[i] = '0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      single_retire();
      independent_burst();
      dependent_chain();
      backpressure_fill();
      exception_flush();
      flush_recovery();

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* rob_core.f */
+incdir+testbench
common/rob_pkg.sv
rob/rob_entry.sv
rob/rob.sv
dispatch/dispatch_stage.sv
verilog/exec_unit.sv
verilog/retire_stage.sv
verilog/rob_core.sv
testbench/tb_rob_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rob_core -f rob_core.f -o sim_rob_core

./obj_dir/sim_rob_core | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Run reported errors, see sim.log"
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "Run ended without a result, see sim.log"
   exit 1
fi
exit 0
